// ==== bench/intExecUnit_stimulus.txt ====
# test op srcA srcB imm tagDst nmDst sqN grant expect result taken target flags
# numbers in hex, grant is a 4-bit pattern cycled per clock, expect 0 means squashed
2 ADD 00000005 00000007 00000000 01 01 01 F 1 0000000c 0 00000000 0
2 SUB 00000003 00000005 00000000 02 02 02 F 1 fffffffe 0 00000000 0
2 XOR f0f0f0f0 ff00ff00 00000000 03 03 03 F 1 0ff00ff0 0 00000000 0
2 OR f0f0f0f0 0f000000 00000000 04 04 04 F 1 fff0f0f0 0 00000000 0
2 AND f0f0f0f0 ff00ff00 00000000 05 05 05 F 1 f000f000 0 00000000 0
2 SLL 00000001 00000024 00000000 06 06 06 F 1 00000010 0 00000000 0
2 SRL 80000000 0000001f 00000000 07 07 07 F 1 00000001 0 00000000 0
2 SRA 80000000 00000004 00000000 08 08 08 F 1 f8000000 0 00000000 0
2 SLT ffffffff 00000001 00000000 09 09 09 F 1 00000001 0 00000000 0
2 SLTU ffffffff 00000001 00000000 0a 0a 0a F 1 00000000 0 00000000 0
2 LUI 00000000 12345000 00000000 0b 0b 0b F 1 12345000 0 00000000 0
2 AUIPC 00001000 00002000 00000000 0c 0c 0c F 1 00003000 0 00000000 0
2 JAL 00000100 00000000 00000200 0d 0d 0d F 1 00000104 1 00000200 0
2 JALR 00000200 00000300 00000010 0e 0e 0e F 1 00000204 1 00000310 0
3 BEQ 00000005 00000005 00000040 00 00 20 F 1 00000000 1 00000040 0
3 BEQ 00000005 00000006 00000040 00 00 21 F 1 00000000 0 00000040 0
3 BNE 00000005 00000006 00000044 00 00 22 F 1 00000000 1 00000044 0
3 BLT 80000000 7fffffff 00000048 00 00 23 F 1 00000000 1 00000048 0
3 BLT 7fffffff 80000000 0000004c 00 00 24 F 1 00000000 0 0000004c 0
3 BGE ffffffff ffffffff 00000050 00 00 25 F 1 00000000 1 00000050 0
3 BGE 80000000 00000000 00000054 00 00 26 F 1 00000000 0 00000054 0
3 BLTU 7fffffff 80000000 00000058 00 00 27 F 1 00000000 1 00000058 0
3 BLTU ffffffff 00000000 0000005c 00 00 28 F 1 00000000 0 0000005c 0
3 BGEU 80000000 7fffffff 00000060 00 00 29 F 1 00000000 1 00000060 0
3 BGEU 00000000 00000001 00000064 00 00 2a F 1 00000000 0 00000064 0
4 BEQ 00000005 00000005 00000100 00 00 30 F 1 00000000 1 00000100 0
4 ADD 00000001 00000001 00000000 11 11 31 F 0 00000002 0 00000000 0
4 ADD 00000002 00000003 00000000 12 12 32 F 1 00000005 0 00000000 0
4 BNE 00000001 00000002 00000200 00 00 38 F 1 00000000 1 00000200 0
4 ADD 00000004 00000004 00000000 13 13 35 F 1 00000008 0 00000000 0
5 ADD 00000001 00000100 00000000 20 14 01 0 1 00000101 0 00000000 0
5 ADD 00000002 00000100 00000000 21 15 02 0 1 00000102 0 00000000 0
5 ADD 00000003 00000100 00000000 22 16 03 0 1 00000103 0 00000000 0
5 ADD 00000004 00000100 00000000 23 17 04 0 1 00000104 0 00000000 0
5 ADD 00000005 00000100 00000000 24 18 05 0 1 00000105 0 00000000 0
5 ADD 00000006 00000100 00000000 25 19 06 0 1 00000106 0 00000000 0
5 ADD 00000007 00000100 00000000 26 1a 07 F 1 00000107 0 00000000 0
5 ADD 00000008 00000100 00000000 27 1b 08 F 1 00000108 0 00000000 0
6 SYS 00000123 00000456 00000000 30 15 10 F 1 00000000 0 00000000 1
6 UNDEF 00000123 00000456 00000000 31 16 11 F 1 00000000 0 00000000 1
6 ADD 00000011 00000022 00000000 01 01 12 F 1 00000033 0 00000000 0
6 ADD 00000033 00000044 00000000 02 00 13 F 1 00000077 0 00000000 0

// ==== bench/intExecUnit_tb.sv ====
`timescale 1ns/10ps
`include "core_config.svh"

module intExecUnit_tb;

    localparam int MAX_LINES = 64;
    localparam int NUM_REGS = 1 << `TAG_WIDTH;

    logic clk = 1'b0;
    logic rst;
    logic opValid;
    execPkg::IssueOp op;
    logic wbGrant;
    logic [`TAG_WIDTH-1:0] rdTag;
    logic stall;
    logic resValid;
    execPkg::AluResult res;
    logic branchValid;
    execPkg::BranchReport branch;
    logic [`XLEN-1:0] rdData;

    int lineTest [MAX_LINES];
    execPkg::IssueOp lineOp [MAX_LINES];
    logic [3:0] lineGrant [MAX_LINES];
    logic lineExp [MAX_LINES];
    logic [31:0] lineRes [MAX_LINES];
    logic lineTaken [MAX_LINES];
    logic [31:0] lineTarget [MAX_LINES];
    logic lineFlags [MAX_LINES];

    int numLines = 0;
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    int limit = 0;
    logic [31:0] lfsr = 32'h58888a1c;
    logic sawStall = 1'b0;
    logic [`XLEN-1:0] refRegs [NUM_REGS];
    execPkg::AluResult resQ [$];
    execPkg::BranchReport brQ [$];
    execPkg::AluResult expRes;
    execPkg::BranchReport expBr;

    intExecUnit u_dut (
        .clk(clk),
        .rst(rst),
        .opValid(opValid),
        .op(op),
        .stall(stall),
        .wbGrant(wbGrant),
        .resValid(resValid),
        .res(res),
        .branchValid(branchValid),
        .branch(branch),
        .rdTag(rdTag),
        .rdData(rdData)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("run timed out after %0d cycles", cycles);
            $display("Errors found");
            $finish;
        end
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic intOpsPkg::OpCodeInt opFromName(input string s);
        case (s)
            "ADD":   return intOpsPkg::INT_ADD;
            "SUB":   return intOpsPkg::INT_SUB;
            "XOR":   return intOpsPkg::INT_XOR;
            "OR":    return intOpsPkg::INT_OR;
            "AND":   return intOpsPkg::INT_AND;
            "SLL":   return intOpsPkg::INT_SLL;
            "SRL":   return intOpsPkg::INT_SRL;
            "SRA":   return intOpsPkg::INT_SRA;
            "SLT":   return intOpsPkg::INT_SLT;
            "SLTU":  return intOpsPkg::INT_SLTU;
            "LUI":   return intOpsPkg::INT_LUI;
            "AUIPC": return intOpsPkg::INT_AUIPC;
            "BEQ":   return intOpsPkg::INT_BEQ;
            "BNE":   return intOpsPkg::INT_BNE;
            "BLT":   return intOpsPkg::INT_BLT;
            "BGE":   return intOpsPkg::INT_BGE;
            "BLTU":  return intOpsPkg::INT_BLTU;
            "BGEU":  return intOpsPkg::INT_BGEU;
            "JAL":   return intOpsPkg::INT_JAL;
            "JALR":  return intOpsPkg::INT_JALR;
            "SYS":   return intOpsPkg::INT_SYS;
            default: return intOpsPkg::INT_UNDEFINED;
        endcase
    endfunction

    function automatic logic isBranchOp(input intOpsPkg::OpCodeInt oc);
        return (oc >= intOpsPkg::INT_BEQ) && (oc <= intOpsPkg::INT_JALR);
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            $display("FAILED at %0t: %s expected %h got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic loadStimulus();
        int fd;
        int n;
        string line;
        string name;
        logic [31:0] t, sa, sb, im, tg, nm, sq, gr, ex, rr, tk, tt, fl;
        fd = $fopen("bench/intExecUnit_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file");
            errors++;
        end else begin
            while (!$feof(fd) && numLines < MAX_LINES) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 3 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%d %s %h %h %h %h %h %h %h %h %h %h %h %h", t, name,
                                sa, sb, im, tg, nm, sq, gr, ex, rr, tk, tt, fl);
                    if (n != 14) begin
                        $display("stimulus line could not be parsed: %s", line);
                        errors++;
                    end else begin
                        lineTest[numLines] = t;
                        lineOp[numLines].srcA = sa;
                        lineOp[numLines].srcB = sb;
                        lineOp[numLines].imm = im;
                        lineOp[numLines].opcode = opFromName(name);
                        lineOp[numLines].tagDst = tg[`TAG_WIDTH-1:0];
                        lineOp[numLines].nmDst = nm[`NM_WIDTH-1:0];
                        lineOp[numLines].sqN = sq[`SQN_WIDTH-1:0];
                        lineGrant[numLines] = gr[3:0];
                        lineExp[numLines] = ex[0];
                        lineRes[numLines] = rr;
                        lineTaken[numLines] = tk[0];
                        lineTarget[numLines] = tt;
                        lineFlags[numLines] = fl[0];
                        numLines++;
                    end
                end
            end
            $fclose(fd);
        end
        limit = 40 * numLines;
    endtask

    // back-pressure test mixes the pattern with random bits, and grants once stalled long
    task automatic setGrant(input int i, input int waitCycles);
        logic patBit;
        patBit = lineGrant[i][cycles % 4];
        if (lineTest[i] == 5) begin
            lfsr = lfsrStep(lfsr);
            wbGrant = lfsr[0] & (patBit | (waitCycles >= 3));
        end else begin
            wbGrant = patBit;
        end
    endtask

    task automatic issueLine(input int i);
        int waitCycles;
        waitCycles = 0;
        op = lineOp[i];
        opValid = 1'b1;
        setGrant(i, waitCycles);
        while (stall) begin
            sawStall = 1'b1;
            @(posedge clk);
            #1;
            waitCycles++;
            setGrant(i, waitCycles);
        end
        if (lineExp[i]) begin
            expRes.result = lineRes[i];
            expRes.tagDst = lineOp[i].tagDst;
            expRes.nmDst = lineOp[i].nmDst;
            expRes.sqN = lineOp[i].sqN;
            expRes.flags = intOpsPkg::Flags'(lineFlags[i]);
            resQ.push_back(expRes);
            expBr.isBranch = isBranchOp(lineOp[i].opcode);
            expBr.taken = lineTaken[i];
            expBr.target = lineTarget[i];
            expBr.sqN = lineOp[i].sqN;
            brQ.push_back(expBr);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic sweepRegs();
        for (int t = 0; t < NUM_REGS; t++) begin
            rdTag = t[`TAG_WIDTH-1:0];
            #1;
            checkValue($sformatf("rdData[%0d]", t), refRegs[t], rdData);
        end
    endtask

    task automatic finishTest(input int n, input int errBefore);
        opValid = 1'b0;
        wbGrant = 1'b1;
        while (resQ.size() > 0 || brQ.size() > 0) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        if (n == 5) begin
            checkValue("stall seen", 32'd1, {31'd0, sawStall});
        end
        if (n == 6) begin
            sweepRegs();
        end
        $display("test %0d done, %0d errors", n, errors - errBefore);
    endtask

    // outputs are compared at the falling edge
    always @(negedge clk) begin
        if (!rst && resValid) begin
            if (resQ.size() == 0) begin
                $display("unexpected result with sqN %0d at %0t", res.sqN, $time);
                errors++;
            end else begin
                expRes = resQ.pop_front();
                checkValue("res.result", expRes.result, res.result);
                checkValue("res.tagDst", expRes.tagDst, res.tagDst);
                checkValue("res.nmDst", expRes.nmDst, res.nmDst);
                checkValue("res.sqN", expRes.sqN, res.sqN);
                checkValue("res.flags", expRes.flags, res.flags);
                if (expRes.nmDst != '0) begin
                    refRegs[expRes.tagDst] = expRes.result;
                end
            end
        end
        if (!rst && branchValid) begin
            if (brQ.size() == 0) begin
                $display("unexpected branch report with sqN %0d at %0t", branch.sqN, $time);
                errors++;
            end else begin
                expBr = brQ.pop_front();
                checkValue("branch.isBranch", expBr.isBranch, branch.isBranch);
                checkValue("branch.taken", expBr.taken, branch.taken);
                checkValue("branch.target", expBr.target, branch.target);
                checkValue("branch.sqN", expBr.sqN, branch.sqN);
            end
        end
    end

    initial begin
        int curTest;
        int errBefore;
        rst = 1'b1;
        opValid = 1'b0;
        op = '0;
        wbGrant = 1'b0;
        rdTag = '0;
        for (int t = 0; t < NUM_REGS; t++) begin
            refRegs[t] = '0;
        end
        loadStimulus();
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        errBefore = errors;
        checkValue("stall", 32'd0, {31'd0, stall});
        checkValue("resValid", 32'd0, {31'd0, resValid});
        checkValue("branchValid", 32'd0, {31'd0, branchValid});
        checkValue("branch.taken", 32'd0, {31'd0, branch.taken});
        sweepRegs();
        $display("test 1 done, %0d errors", errors - errBefore);

        curTest = lineTest[0];
        errBefore = errors;
        for (int i = 0; i < numLines; i++) begin
            if (lineTest[i] != curTest) begin
                finishTest(curTest, errBefore);
                curTest = lineTest[i];
                errBefore = errors;
            end
            issueLine(i);
            // keep later ops out of the squash window except in the squash test
            if (lineExp[i] && lineTaken[i] && lineTest[i] != 4) begin
                opValid = 1'b0;
                @(posedge clk);
                #1;
            end
        end
        if (numLines > 0) begin
            finishTest(curTest, errBefore);
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== hdl/core_config.svh ====
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// execution slice widths
`define SQN_WIDTH 6
`define TAG_WIDTH 6
`define NM_WIDTH 5
`define XLEN 32

`define RESULT_QUEUE_DEPTH 4

`endif

// ==== hdl/execPkg.sv ====
`include "core_config.svh"

package execPkg;

    // operation as delivered by issue, operands already read
    typedef struct packed {
        logic [`XLEN-1:0] srcA;
        logic [`XLEN-1:0] srcB;
        logic [`XLEN-1:0] imm;
        intOpsPkg::OpCodeInt opcode;
        logic [`TAG_WIDTH-1:0] tagDst;
        logic [`NM_WIDTH-1:0] nmDst;
        logic [`SQN_WIDTH-1:0] sqN;
    } IssueOp;

    // result travelling from the ALU through the queue to write-back
    typedef struct packed {
        logic [`XLEN-1:0] result;
        logic [`TAG_WIDTH-1:0] tagDst;
        logic [`NM_WIDTH-1:0] nmDst;
        logic [`SQN_WIDTH-1:0] sqN;
        intOpsPkg::Flags flags;
    } AluResult;

    // branch outcome, reported once per accepted op
    typedef struct packed {
        logic isBranch;
        logic taken;
        logic [`XLEN-1:0] target;
        logic [`SQN_WIDTH-1:0] sqN;
    } BranchReport;

endpackage

// ==== hdl/intAlu.sv ====
`timescale 1ns/10ps
`include "core_config.svh"

module intAlu (
    input  logic clk,
    input  logic rst,

    input  logic opValid,
    input  execPkg::IssueOp op,
    input  logic wbStall,

    output logic aluValid,
    output execPkg::AluResult result,

    output logic branchValid,
    output execPkg::BranchReport branch
);

    logic [`XLEN-1:0] resC;
    intOpsPkg::Flags flagsC;
    logic takenC;
    logic isBranchC;
    logic [`XLEN-1:0] targetC;
    logic [`SQN_WIDTH-1:0] sqDiff;
    logic squash;
    logic accept;

    // data result
    always_comb begin
        case (op.opcode)
            intOpsPkg::INT_ADD,
            intOpsPkg::INT_AUIPC: resC = op.srcA + op.srcB;
            intOpsPkg::INT_SUB:   resC = op.srcA - op.srcB;
            intOpsPkg::INT_XOR:   resC = op.srcA ^ op.srcB;
            intOpsPkg::INT_OR:    resC = op.srcA | op.srcB;
            intOpsPkg::INT_AND:   resC = op.srcA & op.srcB;
            intOpsPkg::INT_SLL:   resC = op.srcA << op.srcB[4:0];
            intOpsPkg::INT_SRL:   resC = op.srcA >> op.srcB[4:0];
            intOpsPkg::INT_SRA:   resC = $signed(op.srcA) >>> op.srcB[4:0];
            intOpsPkg::INT_SLT:
                resC = {{(`XLEN-1){1'b0}}, $signed(op.srcA) < $signed(op.srcB)};
            intOpsPkg::INT_SLTU:
                resC = {{(`XLEN-1){1'b0}}, op.srcA < op.srcB};
            intOpsPkg::INT_LUI:   resC = op.srcB;
            // link address
            intOpsPkg::INT_JAL,
            intOpsPkg::INT_JALR:  resC = op.srcA + `XLEN'd4;
            default:              resC = '0;
        endcase
    end

    always_comb begin
        case (op.opcode)
            intOpsPkg::INT_SYS,
            intOpsPkg::INT_UNDEFINED: flagsC = intOpsPkg::FLAGS_BRK;
            default:                  flagsC = intOpsPkg::FLAGS_NONE;
        endcase
    end

    // branch decision
    always_comb begin
        isBranchC = 1'b1;
        case (op.opcode)
            intOpsPkg::INT_JAL,
            intOpsPkg::INT_JALR: takenC = 1'b1;
            intOpsPkg::INT_BEQ:  takenC = op.srcA == op.srcB;
            intOpsPkg::INT_BNE:  takenC = op.srcA != op.srcB;
            intOpsPkg::INT_BLT:  takenC = $signed(op.srcA) < $signed(op.srcB);
            intOpsPkg::INT_BGE:  takenC = !($signed(op.srcA) < $signed(op.srcB));
            intOpsPkg::INT_BLTU: takenC = op.srcA < op.srcB;
            intOpsPkg::INT_BGEU: takenC = !(op.srcA < op.srcB);
            default: begin
                takenC = 1'b0;
                isBranchC = 1'b0;
            end
        endcase
    end

    // jalr is register relative, everything else carries the target in imm
    assign targetC = (op.opcode == intOpsPkg::INT_JALR) ? op.srcB + op.imm : op.imm;

    // drop ops younger than a taken branch registered last cycle
    assign sqDiff = op.sqN - branch.sqN;
    assign squash = branch.taken && ($signed(sqDiff) > 0);
    assign accept = opValid && !wbStall && !squash;

    always_ff @(posedge clk) begin
        if (rst) begin
            aluValid <= 1'b0;
            branchValid <= 1'b0;
            branch.taken <= 1'b0;
        end else if (accept) begin
            aluValid <= 1'b1;
            branchValid <= 1'b1;

            result.result <= resC;
            result.tagDst <= op.tagDst;
            result.nmDst <= op.nmDst;
            result.sqN <= op.sqN;
            result.flags <= flagsC;

            branch.isBranch <= isBranchC;
            branch.taken <= takenC;
            branch.target <= targetC;
            branch.sqN <= op.sqN;
        end else begin
            aluValid <= 1'b0;
            branchValid <= 1'b0;
            // squash window is a single cycle
            branch.taken <= 1'b0;
        end
    end

endmodule

// ==== hdl/intExecUnit.sv ====
`timescale 1ns/10ps
`include "core_config.svh"

module intExecUnit (
    input  logic clk,
    input  logic rst,

    // issue side
    input  logic opValid,
    input  execPkg::IssueOp op,
    output logic stall,

    // result bus
    input  logic wbGrant,
    output logic resValid,
    output execPkg::AluResult res,

    output logic branchValid,
    output execPkg::BranchReport branch,

    // register file read port
    input  logic [`TAG_WIDTH-1:0] rdTag,
    output logic [`XLEN-1:0] rdData
);

    logic aluValid;
    execPkg::AluResult aluResult;
    execPkg::AluResult qHead;
    logic qNotEmpty;
    logic qPop;

    intAlu u_alu (
        .clk(clk),
        .rst(rst),
        .opValid(opValid),
        .op(op),
        .wbStall(stall),
        .aluValid(aluValid),
        .result(aluResult),
        .branchValid(branchValid),
        .branch(branch)
    );

    resultQueue u_queue (
        .clk(clk),
        .rst(rst),
        .push(aluValid),
        .pushData(aluResult),
        .pop(qPop),
        .head(qHead),
        .notEmpty(qNotEmpty),
        .stall(stall)
    );

    writeback u_wb (
        .clk(clk),
        .rst(rst),
        .notEmpty(qNotEmpty),
        .head(qHead),
        .wbGrant(wbGrant),
        .pop(qPop),
        .resValid(resValid),
        .res(res),
        .rdTag(rdTag),
        .rdData(rdData)
    );

endmodule

// ==== hdl/intOpsPkg.sv ====
package intOpsPkg;

    // integer opcodes seen by the ALU
    typedef enum logic [4:0] {
        INT_ADD,
        INT_SUB,
        INT_XOR,
        INT_OR,
        INT_AND,
        INT_SLL,
        INT_SRL,
        INT_SRA,
        INT_SLT,
        INT_SLTU,
        INT_LUI,
        INT_AUIPC,
        // conditional branches
        INT_BEQ,
        INT_BNE,
        INT_BLT,
        INT_BGE,
        INT_BLTU,
        INT_BGEU,
        // jumps, always taken
        INT_JAL,
        INT_JALR,
        INT_SYS,
        INT_UNDEFINED
    } OpCodeInt;

    // exception flags carried with a result
    typedef enum logic {
        FLAGS_NONE,
        FLAGS_BRK
    } Flags;

endpackage

// ==== hdl/resultQueue.sv ====
`timescale 1ns/10ps
`include "core_config.svh"

module resultQueue (
    input  logic clk,
    input  logic rst,

    input  logic push,
    input  execPkg::AluResult pushData,

    input  logic pop,
    output execPkg::AluResult head,
    output logic notEmpty,

    output logic stall
);

    localparam int DEPTH = `RESULT_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    execPkg::AluResult mem [DEPTH];

    logic [PTR_W-1:0] rdPtr;
    logic [PTR_W-1:0] wrPtr;
    logic [CNT_W-1:0] count;

    assign head = mem[rdPtr];
    assign notEmpty = (count != '0);

    // keep one slot beyond the next push for the result still in the ALU register
    assign stall = (count > CNT_W'(DEPTH - 2));

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= pushData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== hdl/writeback.sv ====
`timescale 1ns/10ps
`include "core_config.svh"

module writeback (
    input  logic clk,
    input  logic rst,

    input  logic notEmpty,
    input  execPkg::AluResult head,
    input  logic wbGrant,
    output logic pop,

    output logic resValid,
    output execPkg::AluResult res,

    input  logic [`TAG_WIDTH-1:0] rdTag,
    output logic [`XLEN-1:0] rdData
);

    localparam int NUM_REGS = 1 << `TAG_WIDTH;

    logic [`XLEN-1:0] regFile [NUM_REGS];
    logic wrEn;

    // drain one entry per granted bus slot
    assign pop = notEmpty && wbGrant;

    // x0 destinations are dropped
    assign wrEn = pop && (head.nmDst != '0);

    assign rdData = regFile[rdTag];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regFile[i] <= '0;
            end
        end else if (wrEn) begin
            regFile[head.tagDst] <= head.result;
        end
    end

    // result broadcast, one cycle after the pop
    always_ff @(posedge clk) begin
        if (rst) begin
            resValid <= 1'b0;
        end else begin
            resValid <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            res <= head;
        end
    end

endmodule

// ==== src.f ====
+incdir+hdl
hdl/intOpsPkg.sv
hdl/execPkg.sv
hdl/intAlu.sv
hdl/resultQueue.sv
hdl/writeback.sv
hdl/intExecUnit.sv
bench/intExecUnit_tb.sv
